// ==== Bender.yml ====
package:
  name: mic_capture

sources:
  - source/mic_audio_pkg.sv
  - source/i2s_mic_receiver.sv
  - source/peak_level_meter.sv
  - source/mic_capture_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/inmp441_model.sv
      - bench/tb_mic_capture.sv

// ==== bench/inmp441_model.sv ====
// behavioural i2s mems microphone: frame queue, slot tracking, msb-first serial data

`timescale 1ns/10ps

module inmp441_model
(
    input        clk,
    input        lr,
    input        ws,
    input        sck,
    output logic sd
);

    import mic_audio_pkg::*;

    localparam int SLOT_BITS = 32;

    logic [SAMPLE_W-1:0] left_q[$];
    logic [SAMPLE_W-1:0] right_q[$];
    logic [7:0]          fill_q[$];
    logic [SAMPLE_W-1:0] cur_left;
    logic [SAMPLE_W-1:0] cur_right;
    logic [7:0]          cur_fill;
    logic                sck_q;
    logic                ws_seen;
    logic                slot_start;
    int                  bit_pos;

    initial
    begin
        sd         = 1'b0;
        sck_q      = 1'b0;
        ws_seen    = 1'b1;          // receiver leaves reset with ws high
        slot_start = 1'b0;
        bit_pos    = 0;
        cur_left   = '0;
        cur_right  = '0;
        cur_fill   = '0;
    end

    // one frame: left word, right word, filler for the unused right bits
    task automatic load_frame(input logic [SAMPLE_W-1:0] left,
                              input logic [SAMPLE_W-1:0] right,
                              input logic [7:0]          fill);
        left_q.push_back(left);
        right_q.push_back(right);
        fill_q.push_back(fill);
    endtask

    // sck edges are seen half a clk after the receiver moves them
    always @(negedge clk)
    begin
        if (!sck_q && sck)
        begin
            // ws is read on the rising edge, as the real part does
            if (ws !== ws_seen)
            begin
                slot_start = 1'b1;
                if (ws == lr)
                begin
                    if (left_q.size() > 0)
                    begin
                        cur_left  = left_q.pop_front();
                        cur_right = right_q.pop_front();
                        cur_fill  = fill_q.pop_front();
                    end
                    else
                    begin
                        cur_left  = '0;         // out of frames, go quiet
                        cur_right = '0;
                        cur_fill  = '0;
                    end
                end
            end
            ws_seen = ws;
        end
        else if (sck_q && !sck)
        begin
            if (slot_start)
            begin
                bit_pos    = 1;                 // msb one sck after ws
                slot_start = 1'b0;
            end
            else if (bit_pos != 0 && bit_pos <= SLOT_BITS)
                bit_pos++;

            if (bit_pos >= 1 && bit_pos <= SAMPLE_W)
                sd = (ws_seen == lr) ? cur_left[SAMPLE_W - bit_pos]
                                     : cur_right[SAMPLE_W - bit_pos];
            else if (ws_seen != lr && bit_pos > SAMPLE_W && bit_pos <= SLOT_BITS)
                sd = cur_fill[bit_pos - SAMPLE_W - 1];  // junk the receiver must ignore
            else
                sd = 1'b0;
        end
        sck_q = sck;
    end

endmodule

// ==== bench/mic_capture_cases.txt ====
// one frame per line: left word, right word, both 24-bit hex
// the left word is captured, the right word must never show up
123456 FFFFFF
6FFFFF 5A1C3E
F00000 FFFFFF
000001 9E37B1
FFFFFF 000000
700000 FFFFFF
ABCDEF 31D4A7
800000 FFFFFF
3C3C3C C8E2F5
0F0F0F FFFFFF
000000 000000
900001 FFFFFF
5A5A5A 7B2D90
C0FFEE FFFFFF
010203 E6A1B4
2468AC FFFFFF
900000 0D5F83
FEDCBA FFFFFF
13579B A9C4E2
7FFFFF FFFFFF

// ==== bench/tb_clock_gen.sv ====
// testbench clock and reset source, 20 ns clock and a two cycle reset

`timescale 1ns/10ps

module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 10;    // ns

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;                     // released on a falling edge
    end

endmodule

// ==== bench/tb_mic_capture.sv ====
// testbench top with case file, mic model, sample and level report checks and timeout

`timescale 1ns/10ps

module tb_mic_capture;

    import mic_audio_pkg::*;

    localparam int NUM_CASES   = 20;
    localparam int NUM_SAMPLES = NUM_CASES + 1;             // zero frame goes first
    localparam int NUM_REPORTS = NUM_SAMPLES / METER_WINDOW;
    localparam int FRAME_CLKS  = 1024;
    localparam int SLOT_SCKS   = 32;
    localparam int MAX_CYCLES  = (NUM_CASES + 4) * FRAME_CLKS * 2;
    localparam int MAX_MAG     = (1 << (SAMPLE_W - 1)) - 1;
    localparam logic [31:0] SEED = 32'hd0e10bfa;

    logic           clk;
    logic           rst;
    logic           lr;
    logic           ws;
    logic           sck;
    logic           sd;
    mic_sample_t    sample;
    level_report_t  level;

    logic [SAMPLE_W-1:0] case_mem  [0:2*NUM_CASES-1];
    logic [SAMPLE_W-1:0] exp_left  [0:NUM_SAMPLES-1];
    logic [SAMPLE_W-1:0] exp_right [0:NUM_SAMPLES-1];

    int          cycle_cnt       = 0;
    int          samples_seen    = 0;
    int          words_checked   = 0;
    int          reports_checked = 0;
    int          last_valid      = 0;
    int          sck_rises       = 0;
    int          ws_edges        = 0;
    int          win_count       = 0;
    int          run_peak        = 0;
    int          report_peak     = 0;
    logic        report_due      = 1'b0;
    logic        sck_q           = 1'b0;
    logic        ws_q            = 1'b1;
    logic [31:0] first_rand;

    tb_clock_gen u_clk_gen
    (
        .clk ( clk ),
        .rst ( rst )
    );

    inmp441_model u_mic
    (
        .clk ( clk ),
        .lr  ( lr  ),
        .ws  ( ws  ),
        .sck ( sck ),
        .sd  ( sd  )
    );

    mic_capture_top DUT
    (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .lr     ( lr     ),
        .ws     ( ws     ),
        .sck    ( sck    ),
        .sd     ( sd     ),
        .sample ( sample ),
        .level  ( level  )
    );

    // |x| of a signed word with the largest negative clamped to the top value
    function automatic int magnitude_of(input logic [SAMPLE_W-1:0] word);
        int value;
        value = $signed(word);
        if (value < 0)
            value = -value;
        if (value > MAX_MAG)
            value = MAX_MAG;
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    task automatic check_reset_state(input string name);
        check_value({name, " sample valid"}, 0, sample.valid);
        check_value({name, " level valid"}, 0, level.valid);
        check_value({name, " ws"}, 1, ws);
        check_value({name, " lr"}, 0, lr);
        check_value({name, " sck"}, 0, sck);
    endtask

    // ws only moves on sck falls so a rise and a ws edge never share a cycle
    task automatic check_framing();
        if (!sck_q && sck)
            sck_rises++;
        if (ws !== ws_q)
        begin
            if (ws_edges > 0)
                check_value("sck rises per ws slot", SLOT_SCKS, sck_rises);
            ws_edges++;
            sck_rises = 0;
        end
        sck_q = sck;
        ws_q  = ws;
    endtask

    task automatic check_level();
        check_value("level strobe", report_due, level.valid);
        if (report_due)
        begin
            check_value($sformatf("level peak, report %0d", reports_checked),
                        report_peak, level.peak);
            check_value($sformatf("level clip, report %0d", reports_checked),
                        report_peak >= CLIP_LEVEL, level.clip);
            reports_checked++;
            report_due = 1'b0;
        end
    endtask

    task automatic handle_sample();
        logic [SAMPLE_W-1:0] want;
        int                  mag;
        if (samples_seen >= NUM_SAMPLES)
            abort_run("more sample strobes arrived than frames were sent");
        if (samples_seen > 0)
            check_value("sample spacing", FRAME_CLKS, cycle_cnt - last_valid);
        last_valid = cycle_cnt;
        want       = exp_left[samples_seen];

        // first word comes from the zero frame and is not compared
        if (samples_seen > 0)
        begin
            check_value($sformatf("right slot rejection %0d", samples_seen), 0,
                        (sample.data === exp_right[samples_seen])
                        && (exp_right[samples_seen] !== want));
            check_value($sformatf("word %0d", samples_seen), want, $unsigned(sample.data));
            words_checked++;
        end

        // reference meter fed from the case words
        mag = magnitude_of(want);
        if (mag > run_peak)
            run_peak = mag;
        win_count++;
        if (win_count == METER_WINDOW)
        begin
            report_peak = run_peak;
            report_due  = 1'b1;         // expected on the next cycle
            run_peak    = 0;
            win_count   = 0;
        end
        samples_seen++;
    endtask

    always @(negedge clk)
    begin
        if (!rst)
        begin
            cycle_cnt++;
            if (cycle_cnt >= MAX_CYCLES)
                abort_run($sformatf("timeout: run not finished after %0d cycles", cycle_cnt));
            check_framing();
            check_level();              // before a new window can raise report_due
            if (sample.valid)
                handle_sample();
        end
    end

    initial
    begin
        first_rand = $urandom(SEED);
        $readmemh("bench/mic_capture_cases.txt", case_mem);

        // sd stays low through the first frame
        exp_left[0]  = '0;
        exp_right[0] = '0;
        u_mic.load_frame('0, '0, first_rand[7:0]);
        for (int i = 0; i < NUM_CASES; i++)
        begin
            if ($isunknown(case_mem[2*i]) || $isunknown(case_mem[2*i+1]))
                abort_run("case file is missing or has too few frames");
            exp_left[i+1]  = case_mem[2*i];
            exp_right[i+1] = case_mem[2*i+1];
            u_mic.load_frame(case_mem[2*i], case_mem[2*i+1], 8'($urandom));
        end

        @(negedge clk);
        check_reset_state("during reset");
        wait (rst == 1'b0);
        @(negedge clk);
        check_reset_state("after reset");

        wait (words_checked == NUM_CASES && reports_checked == NUM_REPORTS);
        @(negedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== mic_capture_top.f ====
source/mic_audio_pkg.sv
source/i2s_mic_receiver.sv
source/peak_level_meter.sv
source/mic_capture_top.sv
bench/tb_clock_gen.sv
bench/inmp441_model.sv
bench/tb_mic_capture.sv

// ==== source/i2s_mic_receiver.sv ====
// i2s microphone receiver: sck and ws generation, left slot capture, sample strobe

`timescale 1ns/10ps

module i2s_mic_receiver
(
    input                               clk,
    input                               rst,
    output logic                        lr,
    output logic                        ws,
    output logic                        sck,
    input  logic                        sd,
    output mic_audio_pkg::mic_sample_t  sample
);

    import mic_audio_pkg::*;

    logic                   clk_en;
    logic [FRAME_CNT_W-1:0] cnt;
    logic                   in_left_slot;
    logic                   sample_bit;
    logic                   word_done;
    logic [SAMPLE_W-1:0]    shift;

    // mic channel select tied low, so it talks in the left slot
    assign lr = 1'b0;

    // fast clocks run the frame logic at half rate
    generate
        if (CLK_MHZ >= CLK_EN_MHZ)
        begin : g_clk_div
            always_ff @(posedge clk or posedge rst)
            begin
                if (rst)
                    clk_en <= 1'b0;
                else
                    clk_en <= ~clk_en;
            end
        end
        else
        begin : g_clk_full
            assign clk_en = 1'b1;
        end
    endgenerate

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (clk_en)
            cnt <= cnt + 1'b1;
    end

    assign sck = cnt[SCK_BIT];              // clk / 16 at 50 MHz

    // half frame is 512 counts, ws flips once per wrap
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ws <= 1'b1;
        else if (clk_en && cnt == FRAME_CNT_W'(WS_TOGGLE_CNT))
            ws <= ~ws;
    end

    assign in_left_slot = (ws == lr);

    // 24 sample points, one per sck period, right before the rising edge
    assign sample_bit = in_left_slot
                        && cnt >= FRAME_CNT_W'(FIRST_BIT_CNT)
                        && cnt <= FRAME_CNT_W'(LAST_BIT_CNT)
                        && cnt[SCK_BIT:0] == BIT_PHASE;

    assign word_done = in_left_slot && cnt == '1;

    // msb first
    always_ff @(posedge clk)
    begin
        if (clk_en && sample_bit)
            shift <= {shift[SAMPLE_W-2:0], sd};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample.data  <= '0;
            sample.valid <= 1'b0;
        end
        else
        begin
            sample.valid <= clk_en && word_done;    // one pulse per frame
            if (clk_en && word_done)
                sample.data <= shift;
        end
    end

endmodule

// ==== source/mic_audio_pkg.sv ====
// shared constants, sample and level report structs, meter state enum

package mic_audio_pkg;

    // system clock, the clock enable halves the rate at and above CLK_EN_MHZ
    localparam int CLK_MHZ    = 50;
    localparam int CLK_EN_MHZ = 100;

    // i2s frame: 9-bit counter, sck from one bit, ws toggle point
    localparam int FRAME_CNT_W   = 9;
    localparam int SCK_BIT       = 3;
    localparam int WS_TOGGLE_CNT = 15;
    localparam int BIT_STEP      = 16;          // clocks per sck period

    localparam int SAMPLE_W = 24;

    // left slot sampling window, just before each sck rise
    localparam int FIRST_BIT_CNT = 39;          // msb arrives 1.5 sck after ws
    localparam int LAST_BIT_CNT  = FIRST_BIT_CNT + (SAMPLE_W - 1) * BIT_STEP;
    localparam logic [SCK_BIT:0] BIT_PHASE = (SCK_BIT + 1)'(FIRST_BIT_CNT % BIT_STEP);

    // level meter
    localparam int LEVEL_W      = 23;           // saturated magnitude of a signed word
    localparam int METER_WINDOW = 4;            // samples per report
    localparam int WIN_CNT_W    = $clog2(METER_WINDOW);
    localparam logic [LEVEL_W-1:0] CLIP_LEVEL = 23'd7340032;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] data;       // two's complement word
        logic                       valid;      // one-cycle strobe
    } mic_sample_t;

    typedef struct packed {
        logic [LEVEL_W-1:0] peak;               // largest magnitude in the window
        logic               clip;               // peak at or above CLIP_LEVEL
        logic               valid;              // one-cycle strobe
    } level_report_t;

    typedef enum logic {
        ACCUMULATE,
        REPORT
    } meter_state_t;

endpackage

// ==== source/mic_capture_top.sv ====
// capture top: i2s receiver feeding the peak level meter

`timescale 1ns/10ps

module mic_capture_top
(
    input                                   clk,
    input                                   rst,

    // microphone pins
    output logic                            lr,
    output logic                            ws,
    output logic                            sck,
    input  logic                            sd,

    // captured words, also fed to the meter
    output mic_audio_pkg::mic_sample_t      sample,

    // one report per meter window
    output mic_audio_pkg::level_report_t    level
);

    // receiver owns all mic timing
    i2s_mic_receiver u_receiver
    (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .lr     ( lr     ),
        .ws     ( ws     ),
        .sck    ( sck    ),
        .sd     ( sd     ),
        .sample ( sample )
    );

    // no back-pressure, meter sees every strobe
    peak_level_meter u_meter
    (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .sample ( sample ),
        .level  ( level  )
    );

endmodule

// ==== source/peak_level_meter.sv ====
// peak level meter: saturating magnitude, windowed peak hold, clip flag, report strobe

`timescale 1ns/10ps

module peak_level_meter
(
    input                                   clk,
    input                                   rst,
    input  mic_audio_pkg::mic_sample_t      sample,
    output mic_audio_pkg::level_report_t    level
);

    import mic_audio_pkg::*;

    meter_state_t           state;
    logic [WIN_CNT_W-1:0]   win_cnt;
    logic [LEVEL_W-1:0]     peak;
    logic [SAMPLE_W-1:0]    abs_word;
    logic [LEVEL_W-1:0]     magnitude;
    logic [LEVEL_W-1:0]     next_peak;
    logic                   last_in_window;

    // |x|, with -2^23 clamped to the largest 23-bit value
    always_comb
    begin
        if (sample.data[SAMPLE_W-1])
            abs_word = ~sample.data + 1'b1;
        else
            abs_word = sample.data;

        if (abs_word[SAMPLE_W-1])
            magnitude = '1;                 // only the most negative word lands here
        else
            magnitude = abs_word[LEVEL_W-1:0];
    end

    assign next_peak      = (magnitude > peak) ? magnitude : peak;
    assign last_in_window = (win_cnt == WIN_CNT_W'(METER_WINDOW - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= ACCUMULATE;
            win_cnt <= '0;
            peak    <= '0;
        end
        else
        begin
            case (state)
                ACCUMULATE:
                begin
                    if (sample.valid)
                    begin
                        peak    <= next_peak;
                        win_cnt <= win_cnt + 1'b1;
                        if (last_in_window)
                            state <= REPORT;
                    end
                end
                REPORT:
                begin
                    // report goes out this cycle, start the next window
                    peak    <= '0;
                    win_cnt <= '0;
                    state   <= ACCUMULATE;
                end
                default:
                    state <= ACCUMULATE;
            endcase
        end
    end

    // report is valid for the single REPORT cycle
    always_comb
    begin
        level.peak  = peak;
        level.clip  = (peak >= CLIP_LEVEL);
        level.valid = (state == REPORT);
    end

endmodule
